// ==== design/tdc_pkg.sv ====
// TDC shared definitions
// Hit status and mux address codes, controller state codes and the
// tagged output word formats
`default_nettype none

package tdc_pkg;

	// Hit information of one sample word
	typedef enum logic [1:0] {
		HS_IDLE   = 2'd0,
		HS_HIT    = 2'd1,
		HS_MISSED = 2'd2
	} hit_status_e;

	// Input multiplexer addresses
	typedef enum logic [1:0] {
		MUX_TRIG  = 2'd0,
		MUX_SIG   = 2'd1,
		MUX_SIG_B = 2'd2,
		MUX_CALIB = 2'd3
	} mux_addr_e;

	localparam int STATE_BITS_DEF = 4;

	// Controller state codes, also used as word tags
	localparam int ST_IDLE      = 0;
	localparam int ST_IDLE_TRIG = 1;
	localparam int ST_TRIGGERED = 2;
	localparam int ST_RIS_EDGE  = 3;
	localparam int ST_FAL_EDGE  = 4;
	localparam int ST_MISSED    = 6;
	localparam int ST_CALIB     = 7;
	localparam int ST_CALIB_HIT = 8;
	localparam int ST_RESET     = 9;

	// Fine position, enough for sample words up to 32 bits
	localparam int FINE_BITS = 5;

	typedef logic [STATE_BITS_DEF-1:0] tag_t;

	typedef struct packed {
		hit_status_e          status;
		logic [FINE_BITS-1:0] fine;
	} hit_info_t;

	// Kind bit sits at bit 0 in both views
	typedef struct packed {
		tag_t                 tag;
		logic [31:0]          coarse;
		logic [FINE_BITS-1:0] fine;
		logic [5:0]           rsvd;
		logic                 kind;
	} event_word_t;

	typedef struct packed {
		tag_t        tag;
		logic [31:0] event_cnt;
		logic [7:0]  miss_cnt;
		logic [2:0]  rsvd;
		logic        kind;
	} status_word_t;

	typedef union packed {
		event_word_t  evt;
		status_word_t stat;
	} tdc_word_u;

endpackage

`default_nettype wire

// ==== design/tdc_sample_deser.sv ====
// TDC sample deserializer
// Picks one delay-line word through the input mux and reduces it to a
// registered hit status and fine position
`default_nettype none

module tdc_sample_deser #(
	parameter int sample_bits = 16
) (
	input  logic                   CLK,
	input  logic                   rst,
	input  logic [sample_bits-1:0] trig_samples,
	input  logic [sample_bits-1:0] sig_samples,
	input  logic [sample_bits-1:0] calib_samples,
	input  logic                   samples_valid,
	input  tdc_pkg::mux_addr_e     mux_addr,
	output tdc_pkg::hit_info_t     hit_info,
	output logic                   tdl_ok
);

	logic [3:0]                      last_bit;
	logic [sample_bits-1:0]          sel_word;
	logic                            sel_prev;
	logic [sample_bits-1:0]          rise;
	logic                            multi;
	logic [tdc_pkg::FINE_BITS-1:0]   first_idx;
	tdc_pkg::hit_status_e            status_d;
	tdc_pkg::hit_status_e            status_q;
	logic [tdc_pkg::FINE_BITS-1:0]   fine_q;

	// Input mux, inverted signal finds falling edges
	always_comb begin
		case (mux_addr)
			tdc_pkg::MUX_TRIG:  sel_word = trig_samples;
			tdc_pkg::MUX_SIG:   sel_word = sig_samples;
			tdc_pkg::MUX_SIG_B: sel_word = ~sig_samples;
			default:            sel_word = calib_samples;
		endcase
		sel_prev = last_bit[mux_addr];
	end

	// Bit 0 is the earliest sample, previous word's last bit precedes it
	assign rise = sel_word & ~{sel_word[sample_bits-2:0], sel_prev};

	// More than one set bit in the transition vector
	assign multi = |(rise & (rise - 1'b1));

	// Priority search, lowest transition wins
	always_comb begin
		first_idx = '0;
		for (int i = sample_bits - 1; i >= 0; i--) begin
			if (rise[i])
				first_idx = tdc_pkg::FINE_BITS'(i);
		end
	end

	always_comb begin
		if (!samples_valid || rise == '0)
			status_d = tdc_pkg::HS_IDLE;
		else if (multi)
			status_d = tdc_pkg::HS_MISSED;
		else
			status_d = tdc_pkg::HS_HIT;
	end

	// Edge continuity per selection
	always_ff @(posedge CLK) begin
		if (rst) begin
			last_bit <= '0;
		end else if (samples_valid) begin
			last_bit[tdc_pkg::MUX_TRIG]  <= trig_samples[sample_bits-1];
			last_bit[tdc_pkg::MUX_SIG]   <= sig_samples[sample_bits-1];
			last_bit[tdc_pkg::MUX_SIG_B] <= ~sig_samples[sample_bits-1];
			last_bit[tdc_pkg::MUX_CALIB] <= calib_samples[sample_bits-1];
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			status_q <= tdc_pkg::HS_IDLE;
			tdl_ok   <= 1'b0;
		end else begin
			status_q <= status_d;
			tdl_ok   <= samples_valid;
		end
	end

	always_ff @(posedge CLK) begin
		fine_q <= first_idx;
	end

	assign hit_info = '{status: status_q, fine: fine_q};

endmodule

`default_nettype wire

// ==== design/tdc_controller.sv ====
// TDC main state machine
// Drives the input mux and the coarse counter, handles arming,
// calibration and trigger-distance mode, and counts events and misses
`default_nettype none

module tdc_controller #(
	parameter int state_bits = 4
) (
	input  logic                  CLK,
	input  logic                  rst,
	input  tdc_pkg::hit_info_t    hit_info,
	input  logic                  tdl_ok,
	input  logic                  arm_flag,
	input  logic                  en,
	input  logic                  en_arm_mode,
	input  logic                  en_calib_mode,
	input  logic                  en_write_trigger_distance,
	output logic                  counter_count,
	output logic                  counter_reset,
	output logic [state_bits-1:0] tdc_state,
	output logic [7:0]            miss_cnt,
	output logic [31:0]           event_cnt,
	output tdc_pkg::mux_addr_e    mux_addr
);

	// State codes at the local width
	localparam logic [state_bits-1:0] S_IDLE      = state_bits'(tdc_pkg::ST_IDLE);
	localparam logic [state_bits-1:0] S_IDLE_TRIG = state_bits'(tdc_pkg::ST_IDLE_TRIG);
	localparam logic [state_bits-1:0] S_TRIGGERED = state_bits'(tdc_pkg::ST_TRIGGERED);
	localparam logic [state_bits-1:0] S_RIS_EDGE  = state_bits'(tdc_pkg::ST_RIS_EDGE);
	localparam logic [state_bits-1:0] S_FAL_EDGE  = state_bits'(tdc_pkg::ST_FAL_EDGE);
	localparam logic [state_bits-1:0] S_MISSED    = state_bits'(tdc_pkg::ST_MISSED);
	localparam logic [state_bits-1:0] S_CALIB     = state_bits'(tdc_pkg::ST_CALIB);
	localparam logic [state_bits-1:0] S_CALIB_HIT = state_bits'(tdc_pkg::ST_CALIB_HIT);
	localparam logic [state_bits-1:0] S_RESET     = state_bits'(tdc_pkg::ST_RESET);

	logic [state_bits-1:0] state;
	logic [state_bits-1:0] state_next;
	logic                  hit;
	logic                  armed;
	logic                  arm_latch;
	logic                  event_done;

	assign tdc_state = state;
	assign hit = (hit_info.status == tdc_pkg::HS_HIT) && tdl_ok;
	assign armed = en_arm_mode ? arm_latch : 1'b1;

	// Mux address and counter control follow the state directly
	always_comb begin
		mux_addr      = tdc_pkg::MUX_TRIG;
		counter_reset = 1'b1;
		counter_count = 1'b0;
		case (state)
			S_IDLE:      mux_addr = tdc_pkg::MUX_SIG;
			S_IDLE_TRIG: mux_addr = tdc_pkg::MUX_TRIG;
			S_TRIGGERED: begin
				mux_addr      = tdc_pkg::MUX_SIG;
				counter_reset = 1'b0;
				counter_count = 1'b1;
			end
			S_RIS_EDGE: begin
				mux_addr      = tdc_pkg::MUX_SIG_B;
				counter_reset = 1'b0;
				counter_count = 1'b1;
			end
			S_FAL_EDGE: begin
				if (en_write_trigger_distance)
					mux_addr = tdc_pkg::MUX_TRIG;
				else
					mux_addr = tdc_pkg::MUX_SIG;
			end
			S_CALIB:     mux_addr = tdc_pkg::MUX_CALIB;
			S_CALIB_HIT: mux_addr = tdc_pkg::MUX_CALIB;
			default:     mux_addr = tdc_pkg::MUX_TRIG;
		endcase
	end

	// Disable and miss override the regular transitions
	always_comb begin
		state_next = state;
		if (!en) begin
			state_next = S_IDLE;
		end else if (hit_info.status == tdc_pkg::HS_MISSED) begin
			state_next = S_MISSED;
		end else begin
			case (state)
				S_IDLE: begin
					if (en_calib_mode)
						state_next = S_CALIB;
					else if (en_write_trigger_distance)
						state_next = S_IDLE_TRIG;
					else if (armed && hit)
						state_next = S_RIS_EDGE;
				end
				S_IDLE_TRIG: begin
					if (en_calib_mode)
						state_next = S_CALIB;
					else if (!en_write_trigger_distance)
						state_next = S_IDLE;
					else if (armed && hit)
						state_next = S_TRIGGERED;
				end
				S_TRIGGERED: begin
					if (hit)
						state_next = S_RIS_EDGE;
				end
				S_RIS_EDGE: begin
					if (hit)
						state_next = S_FAL_EDGE;
				end
				S_FAL_EDGE: begin
					if (en_write_trigger_distance)
						state_next = S_IDLE_TRIG;
					else
						state_next = S_IDLE;
				end
				S_CALIB: begin
					if (!en_calib_mode)
						state_next = S_IDLE_TRIG;
					else if (hit)
						state_next = S_CALIB_HIT;
				end
				S_CALIB_HIT: state_next = S_CALIB;
				S_MISSED:    state_next = S_IDLE_TRIG;
				S_RESET:     state_next = S_IDLE_TRIG;
				default:     state_next = S_RESET;
			endcase
		end
	end

	// A sequence completes when falling edge goes back to an idle state
	assign event_done = (state == S_FAL_EDGE) &&
		((state_next == S_IDLE) || (state_next == S_IDLE_TRIG));

	always_ff @(posedge CLK) begin
		if (rst)
			state <= S_RESET;
		else
			state <= state_next;
	end

	// Arm latch, consumed by a completed falling edge
	always_ff @(posedge CLK) begin
		if (rst || state == S_FAL_EDGE)
			arm_latch <= 1'b0;
		else if (arm_flag)
			arm_latch <= 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (rst || state == S_RESET) begin
			event_cnt <= '0;
			miss_cnt  <= '0;
		end else begin
			if (event_done)
				event_cnt <= event_cnt + 32'd1;
			if (state == S_MISSED)
				miss_cnt <= miss_cnt + 8'd1;
		end
	end

endmodule

`default_nettype wire

// ==== design/tdc_word_broker.sv ====
// TDC word broker
// Keeps the coarse counter and turns state entries of the controller
// into tagged event and status words
`default_nettype none

module tdc_word_broker #(
	parameter int state_bits = 4
) (
	input  logic                          CLK,
	input  logic                          rst,
	input  logic [state_bits-1:0]         tdc_state,
	input  logic                          counter_count,
	input  logic                          counter_reset,
	input  logic [tdc_pkg::FINE_BITS-1:0] fine,
	input  logic [31:0]                   event_cnt,
	input  logic [7:0]                    miss_cnt,
	output logic                          word_valid,
	output tdc_pkg::tdc_word_u            word
);

	logic [31:0]                   coarse;
	logic [state_bits-1:0]         prev_state;
	logic [tdc_pkg::FINE_BITS-1:0] fine_q;
	logic                          entered;
	logic                          is_event;
	logic                          is_miss;
	tdc_pkg::tdc_word_u            word_d;

	// Coarse counter under controller control
	always_ff @(posedge CLK) begin
		if (rst || counter_reset)
			coarse <= '0;
		else if (counter_count)
			coarse <= coarse + 32'd1;
	end

	always_ff @(posedge CLK) begin
		if (rst)
			prev_state <= state_bits'(tdc_pkg::ST_RESET);
		else
			prev_state <= tdc_state;
	end

	// Fine position of the hit that caused the state change
	always_ff @(posedge CLK) begin
		fine_q <= fine;
	end

	assign entered = tdc_state != prev_state;

	always_comb begin
		is_event = (tdc_state == state_bits'(tdc_pkg::ST_TRIGGERED)) ||
			(tdc_state == state_bits'(tdc_pkg::ST_RIS_EDGE)) ||
			(tdc_state == state_bits'(tdc_pkg::ST_FAL_EDGE)) ||
			(tdc_state == state_bits'(tdc_pkg::ST_CALIB_HIT));
		is_miss = tdc_state == state_bits'(tdc_pkg::ST_MISSED);
	end

	always_comb begin
		if (is_miss) begin
			word_d.stat.tag       = tdc_pkg::tag_t'(tdc_state);
			word_d.stat.event_cnt = event_cnt;
			word_d.stat.miss_cnt  = miss_cnt;
			word_d.stat.rsvd      = '0;
			word_d.stat.kind      = 1'b1;
		end else begin
			word_d.evt.tag    = tdc_pkg::tag_t'(tdc_state);
			word_d.evt.coarse = coarse;
			word_d.evt.fine   = fine_q;
			word_d.evt.rsvd   = '0;
			word_d.evt.kind   = 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst)
			word_valid <= 1'b0;
		else
			word_valid <= entered && (is_event || is_miss);
	end

	always_ff @(posedge CLK) begin
		if (entered)
			word <= word_d;
	end

endmodule

`default_nettype wire

// ==== design/tdc_top.sv ====
// TDC channel top level
// Deserializer, controller and word broker for one delay-line channel
`default_nettype none

module tdc_top #(
	parameter int sample_bits = 16,
	parameter int state_bits  = tdc_pkg::STATE_BITS_DEF
) (
	input  logic                   CLK,
	input  logic                   rst,
	input  logic [sample_bits-1:0] trig_samples,
	input  logic [sample_bits-1:0] sig_samples,
	input  logic [sample_bits-1:0] calib_samples,
	input  logic                   samples_valid,
	input  logic                   arm_flag,
	input  logic                   en,
	input  logic                   en_arm_mode,
	input  logic                   en_calib_mode,
	input  logic                   en_write_trigger_distance,
	output logic                   word_valid,
	output tdc_pkg::tdc_word_u     word,
	output logic [state_bits-1:0]  tdc_state,
	output logic [31:0]            event_cnt,
	output logic [7:0]             miss_cnt
);

	tdc_pkg::hit_info_t hit_info;
	tdc_pkg::mux_addr_e mux_addr;
	logic               tdl_ok;
	logic               counter_count;
	logic               counter_reset;

	tdc_sample_deser #(
		.sample_bits(sample_bits)
	) u_deser (
		.CLK          (CLK),
		.rst          (rst),
		.trig_samples (trig_samples),
		.sig_samples  (sig_samples),
		.calib_samples(calib_samples),
		.samples_valid(samples_valid),
		.mux_addr     (mux_addr),
		.hit_info     (hit_info),
		.tdl_ok       (tdl_ok)
	);

	tdc_controller #(
		.state_bits(state_bits)
	) u_ctrl (
		.CLK                      (CLK),
		.rst                      (rst),
		.hit_info                 (hit_info),
		.tdl_ok                   (tdl_ok),
		.arm_flag                 (arm_flag),
		.en                       (en),
		.en_arm_mode              (en_arm_mode),
		.en_calib_mode            (en_calib_mode),
		.en_write_trigger_distance(en_write_trigger_distance),
		.counter_count            (counter_count),
		.counter_reset            (counter_reset),
		.tdc_state                (tdc_state),
		.miss_cnt                 (miss_cnt),
		.event_cnt                (event_cnt),
		.mux_addr                 (mux_addr)
	);

	tdc_word_broker #(
		.state_bits(state_bits)
	) u_broker (
		.CLK          (CLK),
		.rst          (rst),
		.tdc_state    (tdc_state),
		.counter_count(counter_count),
		.counter_reset(counter_reset),
		.fine         (hit_info.fine),
		.event_cnt    (event_cnt),
		.miss_cnt     (miss_cnt),
		.word_valid   (word_valid),
		.word         (word)
	);

endmodule

`default_nettype wire

// ==== dv/tdc_tb.sv ====
// TDC channel testbench
// Drives trigger, signal and calibration sample words through the
// trigger-distance, plain, arming, miss, calibration and disable cases
`default_nettype none

module tdc_tb;

	localparam int sample_bits     = 16;
	localparam int num_sequences   = 20;
	localparam int watchdog_cycles = num_sequences * 40 + 200;

	logic                   CLK;
	logic                   rst;
	logic [sample_bits-1:0] trig_samples;
	logic [sample_bits-1:0] sig_samples;
	logic [sample_bits-1:0] calib_samples;
	logic                   samples_valid;
	logic                   arm_flag;
	logic                   en;
	logic                   en_arm_mode;
	logic                   en_calib_mode;
	logic                   en_write_trigger_distance;
	logic                   word_valid;
	tdc_pkg::tdc_word_u     word;
	logic [3:0]             tdc_state;
	logic [31:0]            event_cnt;
	logic [7:0]             miss_cnt;

	tdc_pkg::tdc_word_u exp_q[$];
	tdc_pkg::tdc_word_u exp_w;
	int                 errors;
	int                 checks;
	int                 cyc;
	int                 events;
	int                 misses;
	int unsigned        seed;

	tdc_top #(
		.sample_bits(sample_bits),
		.state_bits (4)
	) uut (
		.CLK                      (CLK),
		.rst                      (rst),
		.trig_samples             (trig_samples),
		.sig_samples              (sig_samples),
		.calib_samples            (calib_samples),
		.samples_valid            (samples_valid),
		.arm_flag                 (arm_flag),
		.en                       (en),
		.en_arm_mode              (en_arm_mode),
		.en_calib_mode            (en_calib_mode),
		.en_write_trigger_distance(en_write_trigger_distance),
		.word_valid               (word_valid),
		.word                     (word),
		.tdc_state                (tdc_state),
		.event_cnt                (event_cnt),
		.miss_cnt                 (miss_cnt)
	);

	always #2 CLK = ~CLK;

	// Event word fields from the top are tag, coarse, fine, reserved and kind 0
	// Status word fields from the top are tag, event count, miss count, reserved and kind 1
	function automatic tdc_pkg::tdc_word_u expected_word(input logic is_status, input int tag,
			input logic [31:0] value, input logic [7:0] low);
		tdc_pkg::tdc_word_u w;
		if (is_status)
			w = {tag[3:0], value, low, 3'b000, 1'b1};
		else
			w = {tag[3:0], value, low[4:0], 6'b000000, 1'b0};
		return w;
	endfunction

	task check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic int pick(input int lo, input int hi);
		return lo + ($urandom % (hi - lo + 1));
	endfunction

	// Rising edge at bit f with the line high up to the last bit
	function automatic logic [sample_bits-1:0] ones_from(input int f);
		return {sample_bits{1'b1}} << f;
	endfunction

	// Line high below bit h and falling at bit h
	function automatic logic [sample_bits-1:0] ones_below(input int h);
		return ~({sample_bits{1'b1}} << h);
	endfunction

	task drive(input logic [sample_bits-1:0] t, input logic [sample_bits-1:0] s,
			input logic [sample_bits-1:0] c);
		@(negedge CLK);
		trig_samples  = t;
		sig_samples   = s;
		calib_samples = c;
		samples_valid = 1'b1;
		cyc++;
	endtask

	task idle(input int n);
		repeat (n) drive('0, '0, '0);
	endtask

	task expect_event(input int tag, input int coarse, input int fine);
		exp_q.push_back(expected_word(1'b0, tag, coarse, fine[7:0]));
	endtask

	task wait_drain;
		while (exp_q.size() != 0)
			idle(1);
		idle(3);
	endtask

	task pulse_arm;
		@(negedge CLK);
		arm_flag = 1'b1;
		@(negedge CLK);
		arm_flag = 1'b0;
	endtask

	// Optional trigger edge followed by a signal rise and fall
	// Coarse values count sample words from the first edge
	task run_sequence(input logic with_trigger, input logic accepted);
		int d;
		int g;
		int ft;
		int fs;
		int h;
		int start;
		d = pick(2, 12);
		g = pick(2, 7);
		ft = pick(0, 15);
		fs = pick(0, 15);
		h = pick(1, 15);
		start = 0;
		if (with_trigger) begin
			drive(ones_from(ft), '0, '0);
			start = cyc;
			if (accepted)
				expect_event(tdc_pkg::ST_TRIGGERED, 0, ft);
			repeat (d - 1) drive('0, '0, '0);
		end
		drive('0, ones_from(fs), '0);
		if (!with_trigger)
			start = cyc;
		if (accepted)
			expect_event(tdc_pkg::ST_RIS_EDGE, cyc - start, fs);
		repeat (g - 1) drive('0, '1, '0);
		drive('0, ones_below(h), '0);
		if (accepted) begin
			expect_event(tdc_pkg::ST_FAL_EDGE, cyc - start, h);
			events++;
		end
		idle(4);
		wait_drain();
	endtask

	// Two rising transitions in one signal word
	task run_miss;
		logic [sample_bits-1:0] two_rise;
		int a;
		int b;
		a = pick(0, 6);
		b = pick(a + 2, 15);
		two_rise = '0;
		two_rise[a] = 1'b1;
		two_rise[b] = 1'b1;
		drive('0, two_rise, '0);
		exp_q.push_back(expected_word(1'b1, tdc_pkg::ST_MISSED, events, misses[7:0]));
		misses++;
		idle(4);
		wait_drain();
		check_value(miss_cnt, misses, "miss count");
	endtask

	task calib_edge;
		int fc;
		fc = pick(0, 15);
		drive('0, '0, ones_from(fc));
		expect_event(tdc_pkg::ST_CALIB_HIT, 0, fc);
		idle(3);
		wait_drain();
	endtask

	// Compare every output strobe against the oldest expected word
	always @(negedge CLK) begin
		if (!rst && word_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Unexpected output word %h at time %0t", word, $time);
			end else begin
				exp_w = exp_q.pop_front();
				check_value(word.stat.kind, exp_w.stat.kind, "word kind");
				check_value(word, exp_w, $sformatf("word with tag %0d", exp_w.evt.tag));
			end
		end
	end

	initial begin
		repeat (10 + watchdog_cycles) @(posedge CLK);
		$display("Timeout: run did not finish within %0d cycles", watchdog_cycles);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		CLK = 1'b0;
		rst = 1'b1;
		trig_samples = '0;
		sig_samples = '0;
		calib_samples = '0;
		samples_valid = 1'b0;
		arm_flag = 1'b0;
		en = 1'b1;
		en_arm_mode = 1'b0;
		en_calib_mode = 1'b0;
		en_write_trigger_distance = 1'b1;
		errors = 0;
		checks = 0;
		cyc = 0;
		events = 0;
		misses = 0;
		seed = $urandom(74);
		repeat (10) @(negedge CLK);
		rst = 1'b0;
		idle(4);

		// Trigger edge while samples_valid is low is ignored
		@(negedge CLK);
		trig_samples = ones_from(3);
		samples_valid = 1'b0;
		idle(4);

		repeat (4) run_sequence(1'b1, 1'b1);

		// Plain mode
		en_write_trigger_distance = 1'b0;
		idle(4);
		repeat (3) begin
			run_sequence(1'b0, 1'b1);
			check_value(event_cnt, events, "event count");
		end

		// Arming
		en_arm_mode = 1'b1;
		repeat (2) run_sequence(1'b0, 1'b0);
		pulse_arm();
		run_sequence(1'b0, 1'b1);
		run_sequence(1'b0, 1'b0);
		pulse_arm();
		run_sequence(1'b0, 1'b1);
		en_arm_mode = 1'b0;
		check_value(event_cnt, events, "event count after arming");

		repeat (2) run_miss();

		// Calibration and the return to trigger-wait
		en_calib_mode = 1'b1;
		idle(3);
		repeat (4) calib_edge();
		en_write_trigger_distance = 1'b1;
		en_calib_mode = 1'b0;
		idle(3);
		drive('0, '0, ones_from(pick(0, 15)));
		idle(4);
		check_value(tdc_state, tdc_pkg::ST_IDLE_TRIG, "state after calibration");

		// Disabled channel ignores hits and misses
		en = 1'b0;
		idle(3);
		drive(ones_from(pick(0, 15)), '0, '0);
		drive('0, ones_from(pick(0, 15)), '0);
		drive('0, 16'h0202, '0);
		idle(6);
		check_value(tdc_state, tdc_pkg::ST_IDLE, "state while disabled");
		en = 1'b1;
		idle(4);
		check_value(tdc_state, tdc_pkg::ST_IDLE_TRIG, "state after enable");

		idle(10);
		if (exp_q.size() != 0) begin
			errors++;
			$display("Missing %0d expected output words at end of run", exp_q.size());
		end
		$display("Result: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tdc.f ====
design/tdc_pkg.sv
design/tdc_sample_deser.sv
design/tdc_controller.sv
design/tdc_word_broker.sv
design/tdc_top.sv
dv/tdc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the TDC channel simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tdc.f --top-module tdc_tb --Mdir obj_dir
./obj_dir/Vtdc_tb > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation passed"
